// ==== source/dcache_wbuf_pkg.sv ====
package dcache_wbuf_pkg;

  // cache word and byte lanes
  localparam int data_width_lp = 32;
  localparam int mask_width_lp = data_width_lp / 8;
  localparam int lg_mask_width_lp = 2;

  // byte address, bits 6..3 are the set, bit 2 the way slot, 1..0 the offset
  localparam int addr_width_lp = 7;

  localparam int ways_lp = 2;
  localparam int lg_ways_lp = 1;

  localparam int sets_lp = 16;
  localparam int lg_sets_lp = 4;

  // low bit of the set index field
  localparam int set_lsb_lp = lg_mask_width_lp + lg_ways_lp;

  typedef enum logic [1:0] {
    st_byte = 2'b00,
    st_half = 2'b01,
    st_word = 2'b10
  } store_op_e;

endpackage

// ==== source/store_intake.sv ====
module store_intake import dcache_wbuf_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      store_v_i,
  input  store_op_e                 store_op_i,
  input  logic [addr_width_lp-1:0]  store_addr_i,
  input  logic [data_width_lp-1:0]  store_data_i,
  input  logic [lg_ways_lp-1:0]     store_way_i,
  output logic                      store_ready_o,

  input  logic                      wb_ready_i,
  output logic                      wb_v_o,
  output logic [addr_width_lp-1:0]  wb_addr_o,
  output logic [data_width_lp-1:0]  wb_data_o,
  output logic [mask_width_lp-1:0]  wb_mask_o,
  output logic [lg_ways_lp-1:0]     wb_way_o
);

  logic                         v_r;
  logic [data_width_lp-1:0]     data_n;
  logic [mask_width_lp-1:0]     mask_n;
  logic [lg_mask_width_lp-1:0]  offset;
  logic                         accept;

  assign offset = store_addr_i[lg_mask_width_lp-1:0];
  assign accept = store_v_i & store_ready_o;

  assign wb_v_o = v_r & wb_ready_i;  // only offered while the buffer has room
  assign store_ready_o = ~v_r | wb_ready_i;

  always_comb begin
    case (store_op_i)
      st_byte: begin
        data_n = {mask_width_lp{store_data_i[7:0]}};  // byte in every lane
        mask_n = mask_width_lp'(1) << offset;
      end
      st_half: begin
        data_n = {(mask_width_lp/2){store_data_i[15:0]}};
        mask_n = mask_width_lp'(2'b11) << {offset[lg_mask_width_lp-1], 1'b0};
      end
      st_word: begin
        data_n = store_data_i;
        mask_n = '1;
      end
      default: begin
        data_n = store_data_i;
        mask_n = '0;  // unknown size writes nothing
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (accept) begin
      v_r <= 1'b1;
    end else if (wb_v_o) begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      wb_addr_o <= store_addr_i;
      wb_data_o <= data_n;
      wb_mask_o <= mask_n;
      wb_way_o  <= store_way_i;
    end
  end

endmodule

// ==== source/dcache_wbuf.sv ====
module dcache_wbuf import dcache_wbuf_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      v_i,
  input  logic [addr_width_lp-1:0]  addr_i,
  input  logic [data_width_lp-1:0]  data_i,
  input  logic [mask_width_lp-1:0]  mask_i,
  input  logic [lg_ways_lp-1:0]     way_i,
  output logic                      ready_o,

  output logic                      v_o,
  output logic [addr_width_lp-1:0]  addr_o,
  output logic [data_width_lp-1:0]  data_o,
  output logic [mask_width_lp-1:0]  mask_o,
  output logic [lg_ways_lp-1:0]     way_o,
  input  logic                      yumi_i,

  output logic                      empty_o,

  input  logic                      bypass_v_i,
  input  logic [addr_width_lp-1:0]  bypass_addr_i,
  output logic [data_width_lp-1:0]  bypass_data_o,
  output logic [mask_width_lp-1:0]  bypass_mask_o,

  input  logic [lg_sets_lp-1:0]     snoop_index_i,
  input  logic [lg_ways_lp-1:0]     snoop_way_i,
  output logic                      snoop_match_o
);

  // el1 is the head, el0 the younger entry when two are held
  logic [addr_width_lp-1:0]  el0_addr, el1_addr;
  logic [data_width_lp-1:0]  el0_data, el1_data;
  logic [mask_width_lp-1:0]  el0_mask, el1_mask;
  logic [lg_ways_lp-1:0]     el0_way, el1_way;

  logic [1:0] count_r;
  logic el0_valid, el1_valid;
  logic el0_en, el1_en;
  logic shift_sel, head_sel;

  always_comb begin
    v_o = 1'b0;
    el0_valid = 1'b0;
    el1_valid = 1'b0;
    el0_en = 1'b0;
    el1_en = 1'b0;
    shift_sel = 1'b0;
    head_sel = 1'b0;
    case (count_r)
      2'd0: begin
        v_o = v_i;  // flow-through
        el1_en = v_i & ~yumi_i;
      end
      2'd1: begin
        v_o = 1'b1;
        el1_valid = 1'b1;
        el0_en = v_i & ~yumi_i;
        el1_en = v_i & yumi_i;
        head_sel = 1'b1;
      end
      2'd2: begin
        v_o = 1'b1;
        el0_valid = 1'b1;
        el1_valid = 1'b1;
        el0_en = v_i & yumi_i;
        el1_en = yumi_i;  // younger entry moves up
        shift_sel = 1'b1;
        head_sel = 1'b1;
      end
      default: ;
    endcase
  end

  assign empty_o = (count_r == 2'd0);
  assign ready_o = (count_r != 2'd2);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= 2'd0;
    end else begin
      count_r <= count_r + 2'(v_i) - 2'(v_o & yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (el0_en) begin
      el0_addr <= addr_i;
      el0_data <= data_i;
      el0_mask <= mask_i;
      el0_way  <= way_i;
    end
    if (el1_en) begin
      el1_addr <= shift_sel ? el0_addr : addr_i;
      el1_data <= shift_sel ? el0_data : data_i;
      el1_mask <= shift_sel ? el0_mask : mask_i;
      el1_way  <= shift_sel ? el0_way : way_i;
    end
  end

  assign addr_o = head_sel ? el1_addr : addr_i;
  assign data_o = head_sel ? el1_data : data_i;
  assign mask_o = head_sel ? el1_mask : mask_i;
  assign way_o  = head_sel ? el1_way : way_i;

  logic [mask_width_lp-1:0] hit0_mask, hit1_mask, hit_in_mask;
  logic [data_width_lp-1:0] bypass_data_n;

  // word address compare, offset bits ignored
  assign hit0_mask = {mask_width_lp{el0_valid & (bypass_addr_i[addr_width_lp-1:lg_mask_width_lp]
    == el0_addr[addr_width_lp-1:lg_mask_width_lp])}} & el0_mask;
  assign hit1_mask = {mask_width_lp{el1_valid & (bypass_addr_i[addr_width_lp-1:lg_mask_width_lp]
    == el1_addr[addr_width_lp-1:lg_mask_width_lp])}} & el1_mask;
  assign hit_in_mask = {mask_width_lp{v_i & (bypass_addr_i[addr_width_lp-1:lg_mask_width_lp]
    == addr_i[addr_width_lp-1:lg_mask_width_lp])}} & mask_i;

  always_comb begin
    for (int b = 0; b < mask_width_lp; b++) begin
      if (hit_in_mask[b]) begin
        bypass_data_n[8*b +: 8] = data_i[8*b +: 8];  // newest wins
      end else if (hit0_mask[b]) begin
        bypass_data_n[8*b +: 8] = el0_data[8*b +: 8];
      end else begin
        bypass_data_n[8*b +: 8] = el1_data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bypass_mask_o <= '0;
    end else if (bypass_v_i) begin
      bypass_mask_o <= hit_in_mask | hit0_mask | hit1_mask;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bypass_v_i) begin
      bypass_data_o <= bypass_data_n;
    end
  end

  assign snoop_match_o =
      (v_i & (snoop_index_i == addr_i[set_lsb_lp +: lg_sets_lp]) & (snoop_way_i == way_i))
    | (el0_valid & (snoop_index_i == el0_addr[set_lsb_lp +: lg_sets_lp])
       & (snoop_way_i == el0_way))
    | (el1_valid & (snoop_index_i == el1_addr[set_lsb_lp +: lg_sets_lp])
       & (snoop_way_i == el1_way));

endmodule

// ==== source/data_array_writer.sv ====
module data_array_writer import dcache_wbuf_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      drain_v_i,
  input  logic [addr_width_lp-1:0]  drain_addr_i,
  input  logic [data_width_lp-1:0]  drain_data_i,
  input  logic [mask_width_lp-1:0]  drain_mask_i,
  input  logic [lg_ways_lp-1:0]     drain_way_i,
  output logic                      drain_yumi_o,

  input  logic                      load_v_i,
  input  logic [addr_width_lp-1:0]  load_addr_i,
  input  logic [lg_ways_lp-1:0]     load_way_i,
  input  logic [data_width_lp-1:0]  bypass_data_i,
  input  logic [mask_width_lp-1:0]  bypass_mask_i,

  output logic                      load_v_o,
  output logic [data_width_lp-1:0]  load_data_o
);

  logic [data_width_lp-1:0] mem [sets_lp*ways_lp];

  logic [lg_sets_lp+lg_ways_lp-1:0] wr_idx;
  logic [lg_sets_lp+lg_ways_lp-1:0] rd_idx;
  logic [data_width_lp-1:0]         rd_data_r;

  assign wr_idx = {drain_addr_i[set_lsb_lp +: lg_sets_lp], drain_way_i};
  assign rd_idx = {load_addr_i[set_lsb_lp +: lg_sets_lp], load_way_i};

  // single port, a load blocks the drain
  assign drain_yumi_o = drain_v_i & ~load_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < sets_lp*ways_lp; i++) begin
        mem[i] <= '0;
      end
    end else if (drain_yumi_o) begin
      for (int b = 0; b < mask_width_lp; b++) begin
        if (drain_mask_i[b]) begin
          mem[wr_idx][8*b +: 8] <= drain_data_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      load_v_o <= 1'b0;
    end else begin
      load_v_o <= load_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_v_i) begin
      rd_data_r <= mem[rd_idx];
    end
  end

  // pending store bytes override the array word
  always_comb begin
    for (int b = 0; b < mask_width_lp; b++) begin
      load_data_o[8*b +: 8] = bypass_mask_i[b] ? bypass_data_i[8*b +: 8]
                                               : rd_data_r[8*b +: 8];
    end
  end

endmodule

// ==== source/dcache_wbuf_top.sv ====
module dcache_wbuf_top import dcache_wbuf_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic                      store_v_i,
  input  store_op_e                 store_op_i,
  input  logic [addr_width_lp-1:0]  store_addr_i,
  input  logic [data_width_lp-1:0]  store_data_i,
  input  logic [lg_ways_lp-1:0]     store_way_i,
  output logic                      store_ready_o,

  input  logic                      load_v_i,
  input  logic [addr_width_lp-1:0]  load_addr_i,
  input  logic [lg_ways_lp-1:0]     load_way_i,
  output logic                      load_v_o,
  output logic [data_width_lp-1:0]  load_data_o,

  input  logic [lg_sets_lp-1:0]     snoop_index_i,
  input  logic [lg_ways_lp-1:0]     snoop_way_i,
  output logic                      snoop_match_o,

  output logic                      empty_o
);

  logic                      wb_v, wb_ready;
  logic [addr_width_lp-1:0]  wb_addr;
  logic [data_width_lp-1:0]  wb_data;
  logic [mask_width_lp-1:0]  wb_mask;
  logic [lg_ways_lp-1:0]     wb_way;

  logic                      drain_v, drain_yumi;
  logic [addr_width_lp-1:0]  drain_addr;
  logic [data_width_lp-1:0]  drain_data;
  logic [mask_width_lp-1:0]  drain_mask;
  logic [lg_ways_lp-1:0]     drain_way;

  logic [data_width_lp-1:0]  bypass_data;
  logic [mask_width_lp-1:0]  bypass_mask;

  store_intake intake (
    .clk_i, .reset_i,
    .store_v_i, .store_op_i, .store_addr_i, .store_data_i, .store_way_i, .store_ready_o,
    .wb_ready_i(wb_ready), .wb_v_o(wb_v), .wb_addr_o(wb_addr),
    .wb_data_o(wb_data), .wb_mask_o(wb_mask), .wb_way_o(wb_way)
  );

  dcache_wbuf wbuf (
    .clk_i, .reset_i,
    .v_i(wb_v), .addr_i(wb_addr), .data_i(wb_data), .mask_i(wb_mask), .way_i(wb_way),
    .ready_o(wb_ready),
    .v_o(drain_v), .addr_o(drain_addr), .data_o(drain_data), .mask_o(drain_mask),
    .way_o(drain_way), .yumi_i(drain_yumi),
    .empty_o,
    .bypass_v_i(load_v_i), .bypass_addr_i(load_addr_i),  // every load probes the buffer
    .bypass_data_o(bypass_data), .bypass_mask_o(bypass_mask),
    .snoop_index_i, .snoop_way_i, .snoop_match_o
  );

  data_array_writer writer (
    .clk_i, .reset_i,
    .drain_v_i(drain_v), .drain_addr_i(drain_addr), .drain_data_i(drain_data),
    .drain_mask_i(drain_mask), .drain_way_i(drain_way), .drain_yumi_o(drain_yumi),
    .load_v_i, .load_addr_i, .load_way_i,
    .bypass_data_i(bypass_data), .bypass_mask_i(bypass_mask),
    .load_v_o, .load_data_o
  );

endmodule

// ==== tb/dcache_wbuf_properties.sv ====
module dcache_wbuf_properties (
  input logic       clk_i,
  input logic       reset_i,
  input logic [1:0] count_i,
  input logic       head_v_i,
  input logic       yumi_i,
  input logic       empty_i
);

  // two storage elements, never more
  count_le_two: assert property (@(posedge clk_i) disable iff (reset_i) count_i <= 2'd2)
    else $error("write buffer count above two");

  yumi_with_head: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> head_v_i)
    else $error("yumi without a valid head entry");

  empty_after_reset: assert property (@(posedge clk_i) reset_i |=> empty_i)
    else $error("empty_o low after reset");

endmodule

bind dcache_wbuf dcache_wbuf_properties wbuf_props (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .count_i(count_r),
  .head_v_i(v_o),
  .yumi_i(yumi_i),
  .empty_i(empty_o)
);

// ==== tb/tb_dcache_wbuf.sv ====
module tb_dcache_wbuf import dcache_wbuf_pkg::*; ();

  logic clk_i, reset_i;
  logic store_v_i, store_ready_o;
  store_op_e store_op_i;
  logic [6:0] store_addr_i, load_addr_i;
  logic [31:0] store_data_i, load_data_o;
  logic store_way_i, load_way_i, load_v_i, load_v_o;
  logic [3:0] snoop_index_i;
  logic snoop_way_i, snoop_match_o, empty_o;

  logic [7:0] model_mem [128];  // byte image of everything accepted
  logic [31:0] kind_q[$], op_q[$], addr_q[$], data_q[$], exp_q[$];
  logic [8*128-1:0] line;
  int errors = 0;
  int n_lines = 0;
  bit file_ok = 0;
  bit ops_loaded = 0;

  dcache_wbuf_top dcache_wbuf_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] model_word(input logic [6:0] addr);
    logic [6:0] base;
    base = {addr[6:2], 2'b00};
    return {model_mem[base + 7'd3], model_mem[base + 7'd2], model_mem[base + 7'd1],
            model_mem[base]};
  endfunction

  task automatic apply_store(input store_op_e op, input logic [6:0] addr,
                             input logic [31:0] data);
    logic [6:0] base;
    case (op)
      st_byte: model_mem[addr] = data[7:0];
      st_half: begin
        base = {addr[6:1], 1'b0};  // aligned pair
        model_mem[base] = data[7:0];
        model_mem[base + 7'd1] = data[15:8];
      end
      default: begin
        base = {addr[6:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
          model_mem[base + 7'(b)] = data[8*b +: 8];
        end
      end
    endcase
  endtask

  task automatic read_ops();
    int fd;
    int rc;
    int n;
    logic [31:0] k, o, a, d, e;
    fd = $fopen("tb/wbuf_input.txt", "r");
    if (fd != 0) begin
      file_ok = 1;
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 0) begin
          n_lines++;
          n = $sscanf(line, "%h %h %h %h %h", k, o, a, d, e);
          if (n == 5) begin  // comment lines do not parse
            kind_q.push_back(k);
            op_q.push_back(o);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
    ops_loaded = 1;
  endtask

  task automatic send_store(input store_op_e op, input logic [6:0] addr,
                            input logic [31:0] data);
    store_v_i = 1'b1;
    store_op_i = op;
    store_addr_i = addr;
    store_data_i = data;
    store_way_i = addr[2];
    while (!store_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    store_v_i = 1'b0;
    apply_store(op, addr, data);
  endtask

  task automatic load_compare(input logic [6:0] addr, input logic [31:0] exp);
    logic [31:0] want;
    want = model_word(addr);
    load_v_i = 1'b1;
    load_addr_i = addr;
    load_way_i = addr[2];
    @(negedge clk_i);
    load_v_i = 1'b0;
    check_val({31'b0, load_v_o}, 32'd1, "load_v_o one cycle after load");
    check_val(load_data_o, want, "load data against byte model");
    check_val(load_data_o, exp, "load data against input file");
  endtask

  task automatic probe_snoop(input logic [6:0] addr, input logic way, input logic exp);
    snoop_index_i = addr[6:3];
    snoop_way_i = way;
    #1;
    check_val({31'b0, snoop_match_o}, {31'b0, exp}, "snoop match");
  endtask

  task automatic drain_wait();
    @(negedge clk_i);  // intake stage may still hold the last store
    while (!empty_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic stall_run(input logic [31:0] n_loads, input logic [6:0] st_addr,
                           input logic [31:0] st_data, input logic [6:0] ld_addr);
    int k;
    int c;
    bit acc;
    bit saw_low;
    logic [31:0] want;
    k = 0;
    c = 0;
    saw_low = 0;
    while (k < 4 || c < n_loads) begin
      load_v_i = (c < n_loads);
      load_addr_i = ld_addr;
      load_way_i = ld_addr[2];
      store_v_i = (k < 4);
      store_op_i = st_word;
      store_addr_i = st_addr + 7'(4 * k);
      store_data_i = st_data + 32'(k);
      store_way_i = store_addr_i[2];
      acc = (k < 4) && store_ready_o;
      if (c < n_loads && !store_ready_o) begin
        saw_low = 1;
      end
      want = model_word(ld_addr);
      @(negedge clk_i);
      if (acc) begin
        apply_store(st_word, store_addr_i, store_data_i);
        k++;
      end
      if (c < n_loads) begin
        check_val(load_data_o, want, "load during stall run");
        c++;
      end
    end
    load_v_i = 1'b0;
    store_v_i = 1'b0;
    check_val({31'b0, saw_low}, 32'd1, "store_ready_o low during stall run");
  endtask

  // loads hold the port so a word store and a half store to one word both wait in the buffer
  task automatic overlap_run(input logic [6:0] addr, input logic [31:0] d_word,
                             input logic [31:0] d_half);
    logic [31:0] want;
    load_v_i = 1'b1;
    load_addr_i = addr;
    load_way_i = addr[2];
    for (int cyc = 0; cyc < 4; cyc++) begin
      store_v_i = (cyc < 2);
      store_op_i = (cyc == 0) ? st_word : st_half;
      store_addr_i = (cyc == 0) ? addr : addr + 7'd2;
      store_data_i = (cyc == 0) ? d_word : d_half;
      store_way_i = addr[2];
      want = model_word(addr);
      @(negedge clk_i);
      if (cyc < 2) begin
        apply_store(store_op_i, store_addr_i, store_data_i);
      end
      check_val(load_data_o, want, "load with overlapping stores pending");
    end
    load_v_i = 1'b0;
    store_v_i = 1'b0;
  endtask

  initial begin
    wait (ops_loaded);
    repeat ((n_lines + 4) * 50) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", (n_lines + 4) * 50);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int gap;
    int err_before;
    int failed_tests;
    int n_tests;
    logic [31:0] kind, op, addr, data, exp, prev_kind;
    void'($urandom(32'h4bd8));
    failed_tests = 0;
    n_tests = 0;
    prev_kind = 32'd0;
    reset_i = 1'b1;
    store_v_i = 1'b0;
    store_op_i = st_byte;
    store_addr_i = '0;
    store_data_i = '0;
    store_way_i = 1'b0;
    load_v_i = 1'b0;
    load_addr_i = '0;
    load_way_i = 1'b0;
    snoop_index_i = '0;
    snoop_way_i = 1'b0;
    for (int a = 0; a < 128; a++) begin
      model_mem[a] = 8'h00;  // array is cleared by reset
    end
    read_ops();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    if (!file_ok) begin
      $display("could not open tb/wbuf_input.txt");
      errors++;
    end else begin
      check_val({31'b0, empty_o}, 32'd1, "empty_o after reset");
      check_val({31'b0, store_ready_o}, 32'd1, "store_ready_o after reset");
      check_val({31'b0, load_v_o}, 32'd0, "load_v_o after reset");
      check_val({31'b0, snoop_match_o}, 32'd0, "snoop_match_o after reset");
      for (int i = 0; i < kind_q.size(); i++) begin
        kind = kind_q[i];
        op = op_q[i];
        addr = addr_q[i];
        data = data_q[i];
        exp = exp_q[i];
        err_before = errors;
        if (prev_kind == 32'd4) begin
          gap = $urandom % 3;  // idle cycles while the buffer is drained
          repeat (gap) @(negedge clk_i);
        end
        case (kind)
          32'd0: send_store(store_op_e'(op[1:0]), addr[6:0], data);
          32'd1: load_compare(addr[6:0], exp);
          32'd2: stall_run(op, addr[6:0], data, exp[6:0]);
          32'd3: probe_snoop(addr[6:0], op[0], exp[0]);
          default: drain_wait();
        endcase
        n_tests++;
        if (errors != err_before) begin
          failed_tests++;
        end
        $display("test %0d kind %0d addr %h: %s", i, kind, addr[6:0],
                 (errors == err_before) ? "ok" : "mismatch");
        prev_kind = kind;
      end
      err_before = errors;
      overlap_run(7'h60, 32'h11223344, 32'h0000aabb);
      drain_wait();
      load_compare(7'h60, 32'haabb3344);
      n_tests++;
      if (errors != err_before) begin
        failed_tests++;
      end
      $display("test %0d overlapping stores addr 60: %s", kind_q.size(),
               (errors == err_before) ? "ok" : "mismatch");
    end
    $display("tests %0d, failed %0d, check errors %0d", n_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== dcache_wbuf.f ====
source/dcache_wbuf_pkg.sv
source/store_intake.sv
source/dcache_wbuf.sv
source/data_array_writer.sv
source/dcache_wbuf_top.sv
tb/dcache_wbuf_properties.sv
tb/tb_dcache_wbuf.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dcache_wbuf
FILELIST  ?= dcache_wbuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/wbuf_input.txt ====
# kind op addr data expect, hex; kind 0 store, 1 load, 2 stall run, 3 snoop, 4 wait for empty
# store op 0 byte 1 half 2 word; snoop op is the way; stall op is the load count, expect its address
0 0 00 00000011 0
0 0 01 00000022 0
0 0 02 00000033 0
0 0 03 ffffff44 0
0 2 04 a5a5a5a5 0
0 0 06 abcdef5c 0
0 2 08 01020304 0
0 1 0a 0000beef 0
0 2 0c cafef00d 0
0 1 0c 00001234 0
0 1 0f 00005678 0
0 2 12 89abcdef 0
4 0 00 00000000 0
1 0 00 00000000 44332211
1 0 04 00000000 a55ca5a5
1 0 08 00000000 beef0304
1 0 0e 00000000 56781234
1 0 10 00000000 89abcdef
0 0 01 00000099 0
1 0 00 00000000 44339911
0 2 30 aabbccdd 0
1 0 30 00000000 aabbccdd
0 1 32 0000eeff 0
1 0 31 00000000 eeffccdd
0 2 2c 0badf00d 0
3 1 2c 00000000 1
3 0 2c 00000000 0
4 0 00 00000000 0
3 1 2c 00000000 0
4 0 00 00000000 0
2 8 40 10000000 5c
4 0 00 00000000 0
1 0 40 00000000 10000000
1 0 44 00000000 10000001
1 0 48 00000000 10000002
1 0 4c 00000000 10000003
1 0 7c 00000000 00000000
1 0 28 00000000 00000000
